//--- source/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// set index bits, 64 sets by default
`define DCACHE_INDEX_W 6

// byte offset inside a one-word line
`define DCACHE_OFFSET_W 2

// data word and address width
`define DCACHE_WORD_W 32

`endif

//--- source/dcache_pkg.sv
`include "dcache_params.svh"

package dcache_pkg;

    localparam int INDEX_W  = `DCACHE_INDEX_W;
    localparam int OFFSET_W = `DCACHE_OFFSET_W;
    localparam int WORD_W   = `DCACHE_WORD_W;
    // tag is whatever is left of the address
    localparam int TAG_W    = WORD_W - INDEX_W - OFFSET_W;
    localparam int SETS     = 1 << INDEX_W;

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic               way_t;
    typedef logic [3:0]         byte_mask_t;
    typedef logic [1:0]         access_size_t;

    // bus size encodings
    localparam access_size_t SIZE_BYTE = 2'd0;
    localparam access_size_t SIZE_HALF = 2'd1;
    localparam access_size_t SIZE_WORD = 2'd2;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_WBACK  = 2'd1,
        ST_REFILL = 2'd2
    } ctrl_state_e;

endpackage

//--- source/dcache_array_if.sv
`timescale 1ns/1ps

interface dcache_array_if import dcache_pkg::*;
    ();

    // lookup result, combinational on the cpu address
    logic  hit;
    // hit way, or victim way on a miss
    way_t  way;
    logic  victim_dirty;
    tag_t  victim_tag;
    word_t line_data;

    // update commands from the controller
    logic  fill_en;
    logic  store_en;
    logic  touch_en;
    // word written on fill or store hit
    word_t fill_data;
    logic  fill_dirty;

    modport ctrl (
        input  hit, way, victim_dirty, victim_tag, line_data,
        output fill_en, store_en, touch_en, fill_data, fill_dirty
    );

    modport store (
        output hit, way, victim_dirty, victim_tag, line_data,
        input  fill_en, store_en, touch_en, fill_data, fill_dirty
    );

endinterface

//--- source/dcache_store.sv
`timescale 1ns/1ps

module dcache_store import dcache_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t addr,
    dcache_array_if.store arr
);

    // address split
    index_t idx;
    tag_t   tag;

    // per way state bits, one vector per way
    logic [1:0][SETS-1:0] valid_q;
    logic [1:0][SETS-1:0] dirty_q;
    // most recently used way of each set
    logic [SETS-1:0]      ru_q;

    // tag and data storage
    tag_t  tag_mem  [2][SETS];
    word_t data_mem [2][SETS];

    // per way compare
    logic hit0;
    logic hit1;
    way_t sel_way;

    assign idx = addr[OFFSET_W +: INDEX_W];
    assign tag = addr[WORD_W-1 -: TAG_W];

    assign hit0 = valid_q[0][idx] && (tag_mem[0][idx] == tag);
    assign hit1 = valid_q[1][idx] && (tag_mem[1][idx] == tag);

    always_comb begin
        if (hit0) begin
            sel_way = 1'b0;
        end else if (hit1) begin
            sel_way = 1'b1;
        end else begin
            // miss, take the way not used last
            sel_way = ~ru_q[idx];
        end
    end

    assign arr.hit          = hit0 | hit1;
    assign arr.way          = sel_way;
    // on a miss these describe the victim
    assign arr.victim_dirty = valid_q[sel_way][idx] & dirty_q[sel_way][idx];
    assign arr.victim_tag   = tag_mem[sel_way][idx];
    assign arr.line_data    = data_mem[sel_way][idx];

    // state bits
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            ru_q    <= '0;
        end else begin
            if (arr.fill_en) begin
                valid_q[sel_way][idx] <= 1'b1;
                // dirty only when a store missed
                dirty_q[sel_way][idx] <= arr.fill_dirty;
            end else if (arr.store_en) begin
                dirty_q[sel_way][idx] <= 1'b1;
            end
            if (arr.touch_en) begin
                ru_q[idx] <= sel_way;
            end
        end
    end

    // tag and data words
    always_ff @(posedge clk) begin
        if (arr.fill_en) begin
            tag_mem[sel_way][idx] <= tag;
        end
        if (arr.fill_en || arr.store_en) begin
            data_mem[sel_way][idx] <= arr.fill_data;
        end
    end

endmodule

//--- source/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    // processor side
    input  logic         cpu_data_req,
    input  logic         cpu_data_wr,
    input  access_size_t cpu_data_size,
    input  word_t        cpu_data_addr,
    input  word_t        cpu_data_wdata,
    output word_t        cpu_data_rdata,
    output logic         cpu_data_addr_ok,
    output logic         cpu_data_data_ok,
    // memory side
    output logic         cache_data_req,
    output logic         cache_data_wr,
    output access_size_t cache_data_size,
    output word_t        cache_data_addr,
    output word_t        cache_data_wdata,
    input  word_t        cache_data_rdata,
    input  logic         cache_data_addr_ok,
    input  logic         cache_data_data_ok,
    dcache_array_if.ctrl arr
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    // address accepted, waiting for data_ok
    logic wb_addr_rcv_q;
    logic rf_addr_rcv_q;

    logic in_idle;
    logic in_wback;
    logic in_refill;
    logic hit_ack;
    logic refill_done;

    index_t     idx;
    byte_mask_t mask;
    word_t      bit_mask;
    word_t      merge_base;
    word_t      merged;

    assign in_idle   = (state_q == ST_IDLE);
    assign in_wback  = (state_q == ST_WBACK);
    assign in_refill = (state_q == ST_REFILL);

    assign idx = cpu_data_addr[OFFSET_W +: INDEX_W];

    // next state
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ST_IDLE: begin
                if (cpu_data_req && !arr.hit) begin
                    state_d = arr.victim_dirty ? ST_WBACK : ST_REFILL;
                end
            end
            ST_WBACK: begin
                if (cache_data_data_ok) begin
                    state_d = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (cache_data_data_ok) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q       <= ST_IDLE;
            wb_addr_rcv_q <= 1'b0;
            rf_addr_rcv_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // data_ok ends the phase, even alongside addr_ok
            if (in_wback && cache_data_data_ok) begin
                wb_addr_rcv_q <= 1'b0;
            end else if (in_wback && cache_data_req && cache_data_addr_ok) begin
                wb_addr_rcv_q <= 1'b1;
            end
            if (in_refill && cache_data_data_ok) begin
                rf_addr_rcv_q <= 1'b0;
            end else if (in_refill && cache_data_req && cache_data_addr_ok) begin
                rf_addr_rcv_q <= 1'b1;
            end
        end
    end

    // byte enables from size and low address bits
    always_comb begin
        unique case (cpu_data_size)
            SIZE_BYTE: mask = 4'b0001 << cpu_data_addr[1:0];
            SIZE_HALF: mask = cpu_data_addr[1] ? 4'b1100 : 4'b0011;
            default:   mask = 4'b1111;
        endcase
    end

    assign bit_mask = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};

    // refill merges into the memory word, a hit into the cached one
    assign merge_base = in_refill ? cache_data_rdata : arr.line_data;
    assign merged     = (merge_base & ~bit_mask) | (cpu_data_wdata & bit_mask);

    assign hit_ack     = in_idle && cpu_data_req && arr.hit;
    assign refill_done = in_refill && cache_data_data_ok;

    // processor acknowledges, always as a pair
    assign cpu_data_addr_ok = hit_ack | refill_done;
    assign cpu_data_data_ok = hit_ack | refill_done;
    assign cpu_data_rdata   = refill_done ? cache_data_rdata : arr.line_data;

    // array updates
    assign arr.fill_en    = refill_done;
    assign arr.fill_dirty = cpu_data_wr;
    assign arr.fill_data  = cpu_data_wr ? merged : cache_data_rdata;
    assign arr.store_en   = hit_ack && cpu_data_wr;
    assign arr.touch_en   = hit_ack | refill_done;

    // memory request held until addr_ok
    assign cache_data_req   = (in_wback && !wb_addr_rcv_q) || (in_refill && !rf_addr_rcv_q);
    assign cache_data_wr    = in_wback;
    assign cache_data_size  = SIZE_WORD;
    // victim line address on write-back, aligned cpu address on refill
    assign cache_data_addr  = in_wback ? {arr.victim_tag, idx, {OFFSET_W{1'b0}}}
                                       : {cpu_data_addr[WORD_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign cache_data_wdata = arr.line_data;

endmodule

//--- source/dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    // processor load/store port
    input  logic         cpu_data_req,
    input  logic         cpu_data_wr,
    input  access_size_t cpu_data_size,
    input  word_t        cpu_data_addr,
    input  word_t        cpu_data_wdata,
    output word_t        cpu_data_rdata,
    output logic         cpu_data_addr_ok,
    output logic         cpu_data_data_ok,
    // memory port
    output logic         cache_data_req,
    output logic         cache_data_wr,
    output access_size_t cache_data_size,
    output word_t        cache_data_addr,
    output word_t        cache_data_wdata,
    input  word_t        cache_data_rdata,
    input  logic         cache_data_addr_ok,
    input  logic         cache_data_data_ok
);

    // lookup and update path between controller and arrays
    dcache_array_if arr ();

    dcache_ctrl u_ctrl (
        .clk                (clk),
        .rst                (rst),
        .cpu_data_req       (cpu_data_req),
        .cpu_data_wr        (cpu_data_wr),
        .cpu_data_size      (cpu_data_size),
        .cpu_data_addr      (cpu_data_addr),
        .cpu_data_wdata     (cpu_data_wdata),
        .cpu_data_rdata     (cpu_data_rdata),
        .cpu_data_addr_ok   (cpu_data_addr_ok),
        .cpu_data_data_ok   (cpu_data_data_ok),
        .cache_data_req     (cache_data_req),
        .cache_data_wr      (cache_data_wr),
        .cache_data_size    (cache_data_size),
        .cache_data_addr    (cache_data_addr),
        .cache_data_wdata   (cache_data_wdata),
        .cache_data_rdata   (cache_data_rdata),
        .cache_data_addr_ok (cache_data_addr_ok),
        .cache_data_data_ok (cache_data_data_ok),
        .arr                (arr.ctrl)
    );

    // arrays look up the held cpu address directly
    dcache_store u_store (
        .clk  (clk),
        .rst  (rst),
        .addr (cpu_data_addr),
        .arr  (arr.store)
    );

endmodule

//--- verification/dcache_checker.sv
`timescale 1ns/1ps

module dcache_checker import dcache_pkg::*; (
    input logic        clk,
    input logic        rst,
    input ctrl_state_e state,
    input logic        cpu_data_addr_ok,
    input logic        cpu_data_data_ok,
    input logic        cache_data_req,
    input logic        cache_data_wr,
    input logic        cache_data_addr_ok,
    input logic        cache_data_data_ok,
    input word_t       cache_data_addr,
    input word_t       cache_data_wdata
);

    // memory req only rises as a new phase starts
    a_req_at_phase_start: assert property (@(posedge clk) disable iff (rst)
        $rose(cache_data_req) |-> (state != $past(state)))
        else $error("memory req rose without a new phase");

    // write level held until the write's data_ok
    a_wr_held: assert property (@(posedge clk) disable iff (rst)
        (cache_data_wr && !cache_data_data_ok) |=> cache_data_wr)
        else $error("memory wr dropped before the write-back data_ok");

    // cpu acknowledges are one-cycle pulses
    a_ack_pulse: assert property (@(posedge clk) disable iff (rst)
        (cpu_data_addr_ok || cpu_data_data_ok)
        |=> !(cpu_data_addr_ok || cpu_data_data_ok))
        else $error("cpu acknowledge held for more than one cycle");

    // request fields held until addr_ok
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        (cache_data_req && !cache_data_addr_ok)
        |=> ($stable(cache_data_addr) && $stable(cache_data_wdata)))
        else $error("memory addr or wdata changed while waiting for addr_ok");

endmodule

bind dcache_top dcache_checker u_checker (
    .clk                (clk),
    .rst                (rst),
    .state              (u_ctrl.state_q),
    .cpu_data_addr_ok   (cpu_data_addr_ok),
    .cpu_data_data_ok   (cpu_data_data_ok),
    .cache_data_req     (cache_data_req),
    .cache_data_wr      (cache_data_wr),
    .cache_data_addr_ok (cache_data_addr_ok),
    .cache_data_data_ok (cache_data_data_ok),
    .cache_data_addr    (cache_data_addr),
    .cache_data_wdata   (cache_data_wdata)
);

//--- verification/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*; ();

    logic         clk = 1'b0;
    logic         rst;
    logic         cpu_data_req;
    logic         cpu_data_wr;
    access_size_t cpu_data_size;
    word_t        cpu_data_addr;
    word_t        cpu_data_wdata;
    word_t        cpu_data_rdata;
    logic         cpu_data_addr_ok;
    logic         cpu_data_data_ok;
    logic         cache_data_req;
    logic         cache_data_wr;
    access_size_t cache_data_size;
    word_t        cache_data_addr;
    word_t        cache_data_wdata;
    word_t        cache_data_rdata;
    logic         cache_data_addr_ok;
    logic         cache_data_data_ok;

    // reference cache, two ways per set
    logic  m_valid [2][SETS];
    logic  m_dirty [2][SETS];
    tag_t  m_tag   [2][SETS];
    word_t m_data  [2][SETS];
    logic  m_ru    [SETS];
    // reference memory and the responder's own memory
    word_t ref_mem   [word_t];
    word_t mem_array [word_t];
    // memory transactions as the responder saw them
    word_t txn_addr [$];
    logic  txn_wr   [$];
    word_t txn_data [$];

    logic [31:0] cpu_seed;
    logic [31:0] mem_seed;
    tag_t        tag_pool [5];
    index_t      idx_pool [4];
    int          n_hit;
    int          n_clean;
    int          n_dirty;

    dcache_top UUT (.*);

    always #4 clk = ~clk;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(inout logic [31:0] seed, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            seed = lfsr_step(seed);
            v    = {v[30:0], seed[0]};
        end
    endtask

    // contents of a never written word
    function automatic word_t fill_word(input word_t a);
        return {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
    endfunction

    function automatic word_t ref_read(input word_t a);
        return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
    endfunction

    // store merge by size and byte offset
    function automatic word_t merge_word(input word_t old, input word_t wd,
                                         input access_size_t sz, input logic [1:0] off);
        word_t m;
        case (sz)
            SIZE_BYTE: m = 32'h0000_00ff << (8 * off);
            SIZE_HALF: m = off[1] ? 32'hffff_0000 : 32'h0000_ffff;
            default:   m = 32'hffff_ffff;
        endcase
        return (old & ~m) | (wd & m);
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic word_error(input string name, input word_t got, input word_t exp);
        fail_now($sformatf("** Error at %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_rdata(input word_t got, input word_t exp);
        if (got !== exp) begin
            word_error("cpu_data_rdata", got, exp);
        end
    endtask

    task automatic check_mem_addr(input word_t got, input word_t exp);
        if (got !== exp) begin
            word_error("cache_data_addr", got, exp);
        end
    endtask

    task automatic check_wb_data(input word_t got, input word_t exp);
        if (got !== exp) begin
            word_error("cache_data_wdata", got, exp);
        end
    endtask

    task automatic check_mem_size(input access_size_t got, input access_size_t exp);
        if (got !== exp) begin
            fail_now($sformatf("** Error at %0t: cache_data_size is %0d, expected %0d",
                               $time, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("** Error at %0t: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    // one processor access, checked against the model
    task automatic cpu_access(input logic wr, input access_size_t sz, input word_t addr,
                              input word_t wd);
        index_t idx;
        tag_t   tag;
        way_t   w;
        logic   hit;
        logic   wb_exp;
        word_t  wb_addr;
        word_t  wb_data;
        word_t  rf_addr;
        word_t  exp_rdata;
        int     n_exp;
        int     cycles;

        idx     = addr[OFFSET_W +: INDEX_W];
        tag     = addr[WORD_W-1 -: TAG_W];
        rf_addr = {addr[WORD_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        hit     = 1'b1;
        if (m_valid[0][idx] && m_tag[0][idx] == tag) begin
            w = 1'b0;
        end else if (m_valid[1][idx] && m_tag[1][idx] == tag) begin
            w = 1'b1;
        end else begin
            // victim is the way not used last
            hit = 1'b0;
            w   = ~m_ru[idx];
        end
        wb_exp    = !hit && m_valid[w][idx] && m_dirty[w][idx];
        wb_addr   = {m_tag[w][idx], idx, {OFFSET_W{1'b0}}};
        wb_data   = m_data[w][idx];
        exp_rdata = hit ? m_data[w][idx] : ref_read(rf_addr);
        n_exp     = hit ? 0 : (wb_exp ? 2 : 1);

        @(posedge clk);
        #1;
        cpu_data_req   = 1'b1;
        cpu_data_wr    = wr;
        cpu_data_size  = sz;
        cpu_data_addr  = addr;
        cpu_data_wdata = wd;
        @(negedge clk);
        // hits finish in the request cycle, misses never do
        check_flag("cpu_data_data_ok", cpu_data_data_ok, hit);
        cycles = 0;
        while (!cpu_data_data_ok) begin
            cycles++;
            if (cycles > 100) begin
                fail_now($sformatf("access to %h got no data_ok within 100 cycles", addr));
            end
            @(negedge clk);
        end
        check_flag("cpu_data_addr_ok", cpu_data_addr_ok, 1'b1);
        if (!wr) begin
            check_rdata(cpu_data_rdata, exp_rdata);
        end

        if (txn_addr.size() != n_exp) begin
            fail_now($sformatf("access to %h expected %0d memory transactions but saw %0d",
                               addr, n_exp, txn_addr.size()));
        end
        if (wb_exp) begin
            check_flag("cache_data_wr", txn_wr.pop_front(), 1'b1);
            check_mem_addr(txn_addr.pop_front(), wb_addr);
            check_wb_data(txn_data.pop_front(), wb_data);
            ref_mem[wb_addr] = wb_data;
        end
        if (!hit) begin
            check_flag("cache_data_wr", txn_wr.pop_front(), 1'b0);
            check_mem_addr(txn_addr.pop_front(), rf_addr);
            void'(txn_data.pop_front());
            m_valid[w][idx] = 1'b1;
            m_dirty[w][idx] = 1'b0;
            m_tag[w][idx]   = tag;
            m_data[w][idx]  = ref_read(rf_addr);
        end
        if (wr) begin
            m_data[w][idx]  = merge_word(m_data[w][idx], wd, sz, addr[1:0]);
            m_dirty[w][idx] = 1'b1;
        end
        m_ru[idx] = w;
        n_hit   += hit ? 1 : 0;
        n_clean += (!hit && !wb_exp) ? 1 : 0;
        n_dirty += wb_exp ? 1 : 0;

        // req drops in the cycle after data_ok
        @(posedge clk);
        #1;
        cpu_data_req = 1'b0;
    endtask

    // memory responder with random addr_ok and data_ok delays
    initial begin : mem_responder
        logic [1:0]  mem_phase;
        logic [31:0] mem_cnt;
        word_t       mem_addr;
        logic        mem_wr;
        word_t       mem_wdata;

        cache_data_rdata   = '0;
        cache_data_addr_ok = 1'b0;
        cache_data_data_ok = 1'b0;
        mem_seed           = 32'hb542;
        mem_phase          = 2'd0;
        mem_cnt            = '0;
        forever begin
            @(posedge clk);
            #1;
            cache_data_addr_ok = 1'b0;
            cache_data_data_ok = 1'b0;
            cache_data_rdata   = '0;
            if (rst) begin
                mem_phase = 2'd0;
            end else begin
                if (mem_phase == 2'd0 && cache_data_req) begin
                    mem_addr  = cache_data_addr;
                    mem_wr    = cache_data_wr;
                    mem_wdata = cache_data_wdata;
                    txn_addr.push_back(mem_addr);
                    txn_wr.push_back(mem_wr);
                    txn_data.push_back(mem_wdata);
                    // whole words only on the memory side
                    check_mem_size(cache_data_size, SIZE_WORD);
                    take_bits(mem_seed, 2, mem_cnt);
                    mem_phase = 2'd1;
                end
                if (mem_phase == 2'd1) begin
                    // req has to wait for addr_ok
                    check_flag("cache_data_req", cache_data_req, 1'b1);
                    if (mem_cnt == 0) begin
                        cache_data_addr_ok = 1'b1;
                        take_bits(mem_seed, 2, mem_cnt);
                        mem_phase = 2'd2;
                    end else begin
                        mem_cnt = mem_cnt - 1;
                    end
                end else if (mem_phase == 2'd2) begin
                    if (mem_cnt == 0) begin
                        cache_data_data_ok = 1'b1;
                        if (mem_wr) begin
                            mem_array[mem_addr] = mem_wdata;
                        end else begin
                            cache_data_rdata = mem_array.exists(mem_addr) ?
                                               mem_array[mem_addr] : fill_word(mem_addr);
                        end
                        mem_phase = 2'd0;
                    end else begin
                        mem_cnt = mem_cnt - 1;
                    end
                end
            end
        end
    end

    initial begin
        logic [31:0]  r;
        logic [2:0]   sel;
        logic         wr;
        access_size_t sz;
        logic [1:0]   off;
        word_t        wd;

        rst            = 1'b1;
        cpu_data_req   = 1'b0;
        cpu_data_wr    = 1'b0;
        cpu_data_size  = SIZE_WORD;
        cpu_data_addr  = '0;
        cpu_data_wdata = '0;
        cpu_seed       = 32'hb542;
        n_hit          = 0;
        n_clean        = 0;
        n_dirty        = 0;
        // five tags over two ways force conflicts
        tag_pool = '{tag_t'(24'h000000), tag_t'(24'h0a13c5), tag_t'(24'h7f0001),
                     tag_t'(24'h3b5e21), tag_t'(24'hfffff0)};
        idx_pool = '{index_t'(0), index_t'(5), index_t'(33), index_t'(SETS - 1)};
        for (int s = 0; s < SETS; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_dirty[0][s] = 1'b0;
            m_dirty[1][s] = 1'b0;
            m_ru[s]       = 1'b0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int n = 0; n < 400; n++) begin
            take_bits(cpu_seed, 1, r);
            wr = r[0];
            take_bits(cpu_seed, 2, r);
            sz = (r[1:0] == 2'd3) ? SIZE_WORD : r[1:0];
            take_bits(cpu_seed, 3, r);
            sel = 3'(r % 5);
            take_bits(cpu_seed, 2, r);
            off = (sz == SIZE_BYTE) ? r[1:0] : (sz == SIZE_HALF) ? {r[1], 1'b0} : 2'b00;
            take_bits(cpu_seed, 2, r);
            take_bits(cpu_seed, 32, wd);
            cpu_access(wr, sz, {tag_pool[sel], idx_pool[r[1:0]], off}, wd);
        end

        $display("hits %0d, clean misses %0d, dirty misses %0d", n_hit, n_clean, n_dirty);
        $display("No errors");
        $finish;
    end

endmodule

//--- dcache_top.f
+incdir+source
source/dcache_pkg.sv
source/dcache_array_if.sv
source/dcache_store.sv
source/dcache_ctrl.sv
source/dcache_top.sv
verification/dcache_checker.sv
verification/dcache_tb.sv

//--- Makefile
TOP = dcache_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f dcache_top.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f dcache_top.f --top-module $(TOP) -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
